// ==== hw/alu.sv ====
module alu import avr_isa_pkg::*; (
    input  alu_op_t           alu_op,
    input  logic [DATA_W-1:0] op_a,
    input  logic [DATA_W-1:0] op_b,
    input  sreg_t             flags_in,
    output logic [DATA_W-1:0] result,
    output sreg_t             flags_out
);

    localparam int MSB = DATA_W - 1;

    logic [DATA_W:0] wide;      // Extra bit holds carry or borrow
    logic            carry_in;

    assign carry_in = ((alu_op == ADC) || (alu_op == SBC)) && flags_in.c;

    always_comb begin
        flags_out = flags_in;
        wide      = '0;
        result    = op_b;

        case (alu_op)
            ADD, ADC: begin
                wide        = {1'b0, op_a} + {1'b0, op_b} + carry_in;
                result      = wide[MSB:0];
                flags_out.c = wide[DATA_W];
                flags_out.h = (op_a[3] & op_b[3]) | (op_b[3] & ~result[3]) |
                              (~result[3] & op_a[3]);
                flags_out.v = (op_a[MSB] & op_b[MSB] & ~result[MSB]) |
                              (~op_a[MSB] & ~op_b[MSB] & result[MSB]);
            end
            SUB, SBC: begin
                wide        = {1'b0, op_a} - {1'b0, op_b} - carry_in;
                result      = wide[MSB:0];
                flags_out.c = wide[DATA_W];     // Borrow
                flags_out.h = (~op_a[3] & op_b[3]) | (op_b[3] & result[3]) |
                              (result[3] & ~op_a[3]);
                flags_out.v = (op_a[MSB] & ~op_b[MSB] & ~result[MSB]) |
                              (~op_a[MSB] & op_b[MSB] & result[MSB]);
            end
            AND: begin
                result      = op_a & op_b;
                flags_out.v = 1'b0;
            end
            EOR: begin
                result      = op_a ^ op_b;
                flags_out.v = 1'b0;
            end
            OR: begin
                result      = op_a | op_b;
                flags_out.v = 1'b0;
            end
            default: ;      // PASS_B moves op_b, flags untouched
        endcase

        if (alu_op != PASS_B) begin
            flags_out.n = result[MSB];
            flags_out.s = result[MSB] ^ flags_out.v;
            // SBC/CPC chain the zero test across bytes
            flags_out.z = (result == '0) && ((alu_op != SBC) || flags_in.z);
        end
    end

endmodule

// ==== hw/avr_core_top.sv ====
module avr_core_top import avr_isa_pkg::*; #(
    parameter logic [PC_W-1:0] RESET_PC = '0
) (
    input  logic              clock,
    input  logic              arst_n,
    output logic [PC_W-1:0]   pc,
    input  logic [PC_W-1:0]   ir,
    output logic [ADDR_W-1:0] address,
    input  logic [DATA_W-1:0] din_raw,
    output logic [DATA_W-1:0] wb,
    output logic              w,
    input  logic [DATA_W-1:0] kb_ch,
    input  logic              kb_tr,
    output logic              kb_hit
);

    logic [REG_ADDR_W-1:0] rd_idx;
    logic [REG_ADDR_W-1:0] rr_idx;
    logic [REG_ADDR_W-1:0] wr_idx;
    logic [DATA_W-1:0]     rd_data;
    logic [DATA_W-1:0]     rr_data;
    logic [DATA_W-1:0]     op_a;
    logic [DATA_W-1:0]     op_b;
    logic [DATA_W-1:0]     alu_result;
    logic [ADDR_W-1:0]     x_ptr;
    logic                  wr_en;
    logic                  sreg_wr_en;
    alu_op_t               alu_op;
    sreg_t                 alu_flags;
    sreg_t                 sreg;
    sreg_t                 sreg_wr_data;

    data_bus_if bus ();

    // External memory sees the registered bus
    assign address = bus.address;
    assign wb      = bus.wdata;
    assign w       = bus.we;

    execute_control #(
        .RESET_PC (RESET_PC)
    ) i_execute_control (
        .clock        (clock),
        .arst_n       (arst_n),
        .ir           (ir),
        .pc           (pc),
        .rd_idx       (rd_idx),
        .rr_idx       (rr_idx),
        .rd_data      (rd_data),
        .rr_data      (rr_data),
        .x_ptr        (x_ptr),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .alu_op       (alu_op),
        .op_a         (op_a),
        .op_b         (op_b),
        .alu_flags    (alu_flags),
        .sreg_wr_en   (sreg_wr_en),
        .sreg_wr_data (sreg_wr_data),
        .sreg         (sreg),
        .bus          (bus.master)
    );

    register_file i_register_file (
        .clock   (clock),
        .arst_n  (arst_n),
        .rd_idx  (rd_idx),
        .rr_idx  (rr_idx),
        .rd_data (rd_data),
        .rr_data (rr_data),
        .wr_en   (wr_en),
        .wr_idx  (wr_idx),
        .wr_data (alu_result),
        .x_ptr   (x_ptr)
    );

    alu i_alu (
        .alu_op    (alu_op),
        .op_a      (op_a),
        .op_b      (op_b),
        .flags_in  (sreg),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    data_space i_data_space (
        .clock        (clock),
        .arst_n       (arst_n),
        .bus          (bus.slave),
        .din_raw      (din_raw),
        .kb_ch        (kb_ch),
        .kb_tr        (kb_tr),
        .kb_hit       (kb_hit),
        .sreg         (sreg),
        .sreg_wr_en   (sreg_wr_en),
        .sreg_wr_data (sreg_wr_data)
    );

endmodule

// ==== hw/avr_io_pkg.sv ====
package avr_io_pkg;

    // IN/OUT port A lands at data address A + IO_OFFSET
    localparam logic [15:0] IO_OFFSET      = 16'h0020;

    // Keyboard
    localparam logic [15:0] KB_DATA_ADDR   = 16'h0022;
    localparam logic [15:0] KB_STATUS_ADDR = 16'h0023;   // Bit 0 is hit

    // Processor
    localparam logic [15:0] SREG_ADDR      = 16'h005F;

endpackage

// ==== hw/avr_isa_pkg.sv ====
package avr_isa_pkg;

    localparam int REG_ADDR_W = 5;
    localparam int DATA_W     = 8;
    localparam int PC_W       = 16;
    localparam int ADDR_W     = 16;

    // Register-pair view, as in ADD Rd, Rr
    typedef struct packed {
        logic [5:0] group;      // Opcode bits 15:10
        logic       rr_hi;      // Rr bit 4, also the LD/ST direction
        logic [4:0] rd;
        logic [3:0] rr_lo;
    } rr_form_t;

    // Immediate view, as in LDI Rd, K
    typedef struct packed {
        logic [3:0] opcode;
        logic [3:0] k_hi;
        logic [3:0] rd;         // R16 to R31 only
        logic [3:0] k_lo;
    } imm_form_t;

    typedef union packed {
        rr_form_t  rr;
        imm_form_t imm;
    } instr_t;

    typedef enum logic [4:0] {
        PASS_B,
        ADD,
        ADC,
        SUB,
        SBC,
        AND,
        EOR,
        OR
    } alu_op_t;

    // Bit 7 down to bit 0
    typedef struct packed {
        logic i;
        logic t;
        logic h;
        logic s;
        logic v;
        logic n;
        logic z;
        logic c;
    } sreg_t;

endpackage

// ==== hw/data_bus_if.sv ====
interface data_bus_if import avr_isa_pkg::*; ();

    logic [ADDR_W-1:0] address;
    logic [DATA_W-1:0] wdata;
    logic              we;      // One cycle per store
    logic              re;      // Second cycle of a load
    logic [DATA_W-1:0] rdata;   // Combinational from the slave

    modport master (
        output address,
        output wdata,
        output we,
        output re,
        input  rdata
    );

    modport slave (
        input  address,
        input  wdata,
        input  we,
        input  re,
        output rdata
    );

endinterface

// ==== hw/data_space.sv ====
module data_space import avr_isa_pkg::*, avr_io_pkg::*; (
    input  logic              clock,
    input  logic              arst_n,
    data_bus_if.slave         bus,
    input  logic [DATA_W-1:0] din_raw,
    input  logic [DATA_W-1:0] kb_ch,
    input  logic              kb_tr,
    output logic              kb_hit,
    input  sreg_t             sreg,
    output logic              sreg_wr_en,
    output sreg_t             sreg_wr_data
);

    logic kb_trigger;   // Local copy of the keyboard toggle

    assign kb_hit = kb_trigger ^ kb_tr;

    // Read decode, everything unclaimed goes to external RAM
    always_comb begin
        case (bus.address)
            KB_DATA_ADDR:   bus.rdata = kb_ch;
            KB_STATUS_ADDR: bus.rdata = {{(DATA_W-1){1'b0}}, kb_hit};
            SREG_ADDR:      bus.rdata = sreg;
            default:        bus.rdata = din_raw;
        endcase
    end

    // Reading hit=1 acknowledges it
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            kb_trigger <= 1'b0;
        end else if (bus.re && (bus.address == KB_STATUS_ADDR) && kb_hit) begin
            kb_trigger <= ~kb_trigger;
        end
    end

    assign sreg_wr_en   = bus.we && (bus.address == SREG_ADDR);
    assign sreg_wr_data = sreg_t'(bus.wdata);

    a_no_rw_overlap: assert property (@(posedge clock) disable iff (!arst_n)
        !(bus.we && bus.re))
        else $error("data bus read and write in the same cycle");

endmodule

// ==== hw/execute_control.sv ====
module execute_control import avr_isa_pkg::*, avr_io_pkg::*; #(
    parameter logic [PC_W-1:0] RESET_PC = '0
) (
    input  logic                  clock,
    input  logic                  arst_n,
    input  instr_t                ir,
    output logic [PC_W-1:0]       pc,
    output logic [REG_ADDR_W-1:0] rd_idx,
    output logic [REG_ADDR_W-1:0] rr_idx,
    input  logic [DATA_W-1:0]     rd_data,
    input  logic [DATA_W-1:0]     rr_data,
    input  logic [ADDR_W-1:0]     x_ptr,
    output logic                  wr_en,
    output logic [REG_ADDR_W-1:0] wr_idx,
    output alu_op_t               alu_op,
    output logic [DATA_W-1:0]     op_a,
    output logic [DATA_W-1:0]     op_b,
    input  sreg_t                 alu_flags,
    input  logic                  sreg_wr_en,
    input  sreg_t                 sreg_wr_data,
    output sreg_t                 sreg,
    data_bus_if.master            bus
);

    logic              tstate;      // Second cycle of LD / IN
    logic [PC_W-1:0]   pc_inc;
    logic [PC_W-1:0]   pc_next;
    logic [DATA_W-1:0] k_imm;
    logic [ADDR_W-1:0] mem_addr;
    logic              use_imm;
    logic              flags_en;
    logic              mem_op;
    logic              is_store;
    logic              is_load;

    assign pc_inc = pc + 1'b1;
    assign k_imm  = {ir.imm.k_hi, ir.imm.k_lo};

    // ----------------------------------------------------------------------
    // Instruction decode
    // ----------------------------------------------------------------------
    always_comb begin
        alu_op   = PASS_B;
        use_imm  = 1'b0;
        wr_en    = 1'b0;
        flags_en = 1'b0;
        mem_op   = 1'b0;
        is_store = 1'b0;
        mem_addr = x_ptr;
        pc_next  = pc_inc;

        casez (ir.rr.group)
            6'b0000_01: begin alu_op = SBC; flags_en = 1'b1; end               // CPC
            6'b0000_10: begin alu_op = SBC; flags_en = 1'b1; wr_en = 1'b1; end
            6'b0000_11: begin alu_op = ADD; flags_en = 1'b1; wr_en = 1'b1; end
            6'b0001_01: begin alu_op = SUB; flags_en = 1'b1; end               // CP
            6'b0001_10: begin alu_op = SUB; flags_en = 1'b1; wr_en = 1'b1; end
            6'b0001_11: begin alu_op = ADC; flags_en = 1'b1; wr_en = 1'b1; end
            6'b0010_00: begin alu_op = AND; flags_en = 1'b1; wr_en = 1'b1; end
            6'b0010_01: begin alu_op = EOR; flags_en = 1'b1; wr_en = 1'b1; end
            6'b0010_10: begin alu_op = OR;  flags_en = 1'b1; wr_en = 1'b1; end
            6'b0010_11: wr_en = 1'b1;                                          // MOV

            // Immediate group, Rd in R16..R31
            6'b0011_??: begin alu_op = SUB; flags_en = 1'b1; use_imm = 1'b1; end   // CPI
            6'b0100_??: begin
                alu_op   = SBC;
                flags_en = 1'b1;
                wr_en    = 1'b1;
                use_imm  = 1'b1;
            end
            6'b0101_??: begin
                alu_op   = SUB;
                flags_en = 1'b1;
                wr_en    = 1'b1;
                use_imm  = 1'b1;
            end
            6'b0110_??: begin
                alu_op   = OR;
                flags_en = 1'b1;
                wr_en    = 1'b1;
                use_imm  = 1'b1;
            end
            6'b0111_??: begin
                alu_op   = AND;
                flags_en = 1'b1;
                wr_en    = 1'b1;
                use_imm  = 1'b1;
            end
            6'b1110_??: begin use_imm = 1'b1; wr_en = 1'b1; end               // LDI

            // Flow control
            6'b1100_??: pc_next = pc_inc + {{(PC_W-12){ir[11]}}, ir[11:0]};   // RJMP
            6'b1111_0?: begin
                // Bit 10 picks BRBC over BRBS
                if (sreg[ir[2:0]] ^ ir[10]) begin
                    pc_next = pc_inc + {{(PC_W-7){ir[9]}}, ir[9:3]};
                end
            end

            // LD Rd,X and ST X,Rr
            6'b1001_00: begin
                if (ir.rr.rr_lo == 4'b1100) begin
                    mem_op   = 1'b1;
                    is_store = ir.rr.rr_hi;
                end
            end

            // IN / OUT, bit 11 is OUT
            6'b1011_??: begin
                mem_op   = 1'b1;
                is_store = ir[11];
                mem_addr = ADDR_W'({ir[10:9], ir[3:0]}) + IO_OFFSET;
            end

            default: ;      // NOP and anything unsupported
        endcase

        is_load = mem_op && !is_store;
        if (is_load) begin
            if (tstate) begin
                wr_en = 1'b1;       // Capture rdata into Rd
            end else begin
                pc_next = pc;       // Hold for the data cycle
            end
        end
    end

    // Operand routing
    assign rd_idx = use_imm ? {1'b1, ir.imm.rd} : ir.rr.rd;
    assign rr_idx = {ir.rr.rr_hi, ir.rr.rr_lo};
    assign wr_idx = rd_idx;
    assign op_a   = rd_data;
    assign op_b   = tstate  ? bus.rdata :
                    use_imm ? k_imm     : rr_data;

    assign bus.re = tstate;

    // ----------------------------------------------------------------------
    // State
    // ----------------------------------------------------------------------
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            pc     <= RESET_PC;
            tstate <= 1'b0;
            sreg   <= '0;
            bus.we <= 1'b0;
        end else begin
            pc     <= pc_next;
            tstate <= is_load && !tstate;
            bus.we <= mem_op && is_store;

            // A flag-setting instruction is younger than a pending SREG store
            if (flags_en) begin
                sreg <= alu_flags;
            end else if (sreg_wr_en) begin
                sreg <= sreg_wr_data;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (mem_op && !tstate) begin
            bus.address <= mem_addr;
            bus.wdata   <= rd_data;     // ST/OUT source sits in the Rd field
        end
    end

    a_tstate_load: assert property (@(posedge clock) disable iff (!arst_n)
        tstate |-> is_load)
        else $error("tstate set while no load opcode is held");

endmodule

// ==== hw/register_file.sv ====
module register_file import avr_isa_pkg::*; (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic [REG_ADDR_W-1:0] rd_idx,
    input  logic [REG_ADDR_W-1:0] rr_idx,
    output logic [DATA_W-1:0]     rd_data,
    output logic [DATA_W-1:0]     rr_data,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_idx,
    input  logic [DATA_W-1:0]     wr_data,
    output logic [ADDR_W-1:0]     x_ptr
);

    logic [DATA_W-1:0] regs [1 << REG_ADDR_W];

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign rd_data = regs[rd_idx];
    assign rr_data = regs[rr_idx];
    assign x_ptr   = {regs[27], regs[26]};     // X = R27:R26

    a_wr_idx_known: assert property (@(posedge clock) disable iff (!arst_n)
        wr_en |-> !$isunknown(wr_idx))
        else $error("register write with unknown index");

endmodule

// ==== sources.f ====
hw/avr_isa_pkg.sv
hw/avr_io_pkg.sv
hw/data_bus_if.sv
hw/alu.sv
hw/register_file.sv
hw/data_space.sv
hw/execute_control.sv
hw/avr_core_top.sv
tb/tb_avr_core.sv

// ==== tb/avr_vectors.txt ====
# P word | M addr byte (RAM preset) | K cycle char | E addr byte (expected write)
# Results go to 0100 through X = R27:R26
P E0B1
P E0A0
P E30A
P EC18
P 0F01
P 930C
P 1F01
P 930C
P 1B01
P 930C
P 0B01
P 930C
P 2301
P 930C
P 2701
P 930C
P 2B01
P 930C
P 2F20
P 1721
P 0721
P 932C
P B73F
P 933C
P 5100
P 4B08
P 930C
P B73F
P 933C
P 650A
P 700F
P 930C
P 300B
P B73F
P 933C
P 930C
P E043
P 5041
P 934C
P F7E9
P 6440
P F009
P 934C
P E1A0
P 915C
P 5F59
P E0A0
P 935C
P B163
P 936C
P B162
P 936C
P B163
P 936C
P CFFF
M 0110 5C
K 10 41
E 0100 02
E 0100 CB
E 0100 03
E 0100 3B
E 0100 08
E 0100 C0
E 0100 C8
E 0100 C8
E 0100 02
E 0100 00
E 0100 00
E 0100 0A
E 0100 35
E 0100 0A
E 0100 02
E 0100 01
E 0100 00
E 0100 40
E 0100 63
E 0100 01
E 0100 41
E 0100 00

// ==== tb/tb_avr_core.sv ====
module tb_avr_core;

    logic        clock;
    logic        arst_n;
    logic [15:0] pc;
    logic [15:0] ir;
    logic [15:0] address;
    logic [7:0]  din_raw;
    logic [7:0]  wb;
    logic        w;
    logic [7:0]  kb_ch;
    logic        kb_tr;
    logic        kb_hit;

    logic [15:0] program_mem [65536];
    logic [7:0]  ram [65536];
    logic [15:0] exp_addr [$];
    logic [7:0]  exp_data [$];
    logic [15:0] next_addr;
    logic [7:0]  next_data;
    logic [15:0] last_pc;
    logic [7:0]  kb_char;
    int          kb_at;
    int          n_words;
    int          errors;
    int          cycles;
    int          timeout_limit;
    bit          done;

    avr_core_top i_avr_core_top (
        .clock   (clock),
        .arst_n  (arst_n),
        .pc      (pc),
        .ir      (ir),
        .address (address),
        .din_raw (din_raw),
        .wb      (wb),
        .w       (w),
        .kb_ch   (kb_ch),
        .kb_tr   (kb_tr),
        .kb_hit  (kb_hit)
    );

    // Program and RAM models
    assign ir      = program_mem[pc];
    assign din_raw = ram[address];

    always @(posedge clock) begin
        if (w) ram[address] <= wb;
    end

    always #4 clock = ~clock;

    task automatic compare(input string what, input logic [15:0] got,
                           input logic [15:0] expected);
        if (got !== expected) begin
            errors++;
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    // ----------------------------------------------------------------------
    // Each vector line starts with a tag letter
    // ----------------------------------------------------------------------
    task automatic load_vectors();
        int             fd;
        int             n;
        logic [63:0]    tag;
        logic [1023:0]  line;
        logic [15:0]    word;
        logic [7:0]     byte_val;
        fd = $fopen("tb/avr_vectors.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the vector file tb/avr_vectors.txt");
            return;
        end
        while (!$feof(fd)) begin
            tag = '0;
            n = $fscanf(fd, "%s", tag);
            if (n == 1) begin
                if (tag == "P") begin
                    n = $fscanf(fd, "%h", word);
                    program_mem[n_words] = word;
                    n_words++;
                end else if (tag == "M") begin
                    n = $fscanf(fd, "%h %h", word, byte_val);
                    ram[word] = byte_val;
                end else if (tag == "K") begin
                    n = $fscanf(fd, "%d %h", kb_at, kb_char);
                end else if (tag == "E") begin
                    n = $fscanf(fd, "%h %h", word, byte_val);
                    exp_addr.push_back(word);
                    exp_data.push_back(byte_val);
                end else begin
                    n = $fgets(line, fd);      // Rest of a comment
                end
            end
        end
        $fclose(fd);
    endtask

    // Write checks sampled mid-cycle
    always @(negedge clock) begin
        if (arst_n && w) begin
            if (exp_addr.size() == 0) begin
                errors++;
                $display("Unexpected write of %h to address %h at time %0t", wb, address, $time);
            end else begin
                next_addr = exp_addr.pop_front();
                next_data = exp_data.pop_front();
                compare("write address", address, next_addr);
                compare("write data", {8'h00, wb}, {8'h00, next_data});
            end
        end
    end

    initial begin
        clock   = 1'b0;
        arst_n  = 1'b0;
        kb_ch   = 8'h00;
        kb_tr   = 1'b0;
        errors  = 0;
        n_words = 0;
        kb_at   = -1;
        done    = 1'b0;
        for (int i = 0; i < 65536; i++) begin
            program_mem[i] = 16'h0000;
            ram[i]         = i[7:0] ^ i[15:8] ^ 8'h5A;   // Address-dependent fill
        end
        load_vectors();
        timeout_limit = 3 * n_words + 50;

        repeat (3) begin
            @(negedge clock);
            compare("pc in reset", pc, 16'h0000);
            compare("w in reset", {15'b0, w}, 16'h0000);
        end
        @(posedge clock);
        #1 arst_n = 1'b1;
        @(negedge clock);
        compare("pc after reset", pc, 16'h0000);
        compare("w after reset", {15'b0, w}, 16'h0000);

        cycles  = 0;
        last_pc = 16'hFFFF;
        while (!done && cycles < timeout_limit) begin
            @(posedge clock);
            #1;
            cycles++;
            if (cycles == kb_at) begin
                kb_ch = kb_char;
                kb_tr = ~kb_tr;     // One key event
            end
            // Hit stays up until the program reads the status port
            if (cycles == kb_at + 1) begin
                compare("kb_hit after key", {15'b0, kb_hit}, 16'h0001);
            end
            if (ir == 16'hCFFF && pc == last_pc) done = 1'b1;
            last_pc = pc;
        end

        if (!done) begin
            errors++;
            $display("Timeout: final jump not reached within %0d cycles", timeout_limit);
        end
        if (exp_addr.size() != 0) begin
            errors++;
            $display("%0d expected writes never happened", exp_addr.size());
        end
        compare("kb_hit at end", {15'b0, kb_hit}, 16'h0000);

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
